// ==== rtl/icache_pkg.sv ====
package icache_pkg;

    // Fetch-side address and instruction widths.
    localparam int ADDR_W   = 32;
    localparam int INSTR_W  = 32;

    // Line geometry: 16-byte lines, 64 of them, direct mapped.
    localparam int OFFSET_W = 4;                          // Byte offset within a line.
    localparam int INDEX_W  = 6;                          // Selects one of the lines.
    localparam int LINES    = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 22 bits.

    // Word number sits just above the byte offset within a word.
    localparam int WORD_LSB = 2;
    localparam int WORD_W   = OFFSET_W - WORD_LSB;

    // Byte address from the fetch stage.
    typedef logic [ADDR_W-1:0]  addr_t;

    // One instruction word.
    typedef logic [INSTR_W-1:0] instr_t;

    // Stored tag and line index.
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // Word within a line, address bits 3:2.
    typedef logic [WORD_W-1:0]  word_sel_t;

endpackage

// ==== rtl/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // A refill moves one whole line in a single beat.
    localparam int LINE_W      = 128;

    // Line-aligned address, the byte offset dropped.
    localparam int LINE_ADDR_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W;

    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // Controller states.
    // LOOKUP serves hits, MEM_WAIT waits for the memory line,
    // REFILL writes it and delivers the word.
    typedef enum logic [1:0] {
        LOOKUP   = 2'd0,
        MEM_WAIT = 2'd1,
        REFILL   = 2'd2
    } ctrl_state_t;

endpackage

// ==== rtl/icache_array_if.sv ====
`timescale 1ns/1ns

interface icache_array_if;

    // Lookup request, sampled by the array on the clock edge.
    logic                   lookup_en;
    icache_pkg::addr_t      lookup_addr;

    // Line write at the end of a refill.
    logic                   wr_en;
    icache_pkg::addr_t      wr_addr;
    mem_bus_pkg::line_t     wr_line;

    // Lookup result, one cycle after lookup_en.
    logic                   hit;
    mem_bus_pkg::line_t     rd_line;

    modport ctrl (
        output lookup_en,
        output lookup_addr,
        output wr_en,
        output wr_addr,
        output wr_line,
        input  hit,
        input  rd_line
    );

    modport array (
        input  lookup_en,
        input  lookup_addr,
        input  wr_en,
        input  wr_addr,
        input  wr_line,
        output hit,
        output rd_line
    );

endinterface

// ==== rtl/icache_array.sv ====
`timescale 1ns/1ns

module icache_array (
    input  logic          clk_i,
    input  logic          rst_i,
    icache_array_if.array arr
);

    mem_bus_pkg::line_t           data_mem [icache_pkg::LINES];
    icache_pkg::tag_t             tag_mem  [icache_pkg::LINES];
    logic [icache_pkg::LINES-1:0] valid_q;

    icache_pkg::index_t lookup_index;
    icache_pkg::tag_t   lookup_tag;
    icache_pkg::index_t wr_index;
    icache_pkg::tag_t   wr_tag;

    // Registered lookup address, split into index and tag.
    icache_pkg::index_t lookup_index_q;
    icache_pkg::tag_t   lookup_tag_q;

    assign lookup_index = arr.lookup_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign lookup_tag   = arr.lookup_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign wr_index     = arr.wr_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign wr_tag       = arr.wr_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];

    // Valid bits all clear together on reset.
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
        end else if (arr.wr_en) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr.wr_en) begin
            data_mem[wr_index] <= arr.wr_line;
            tag_mem[wr_index]  <= wr_tag;
        end
    end

    // Hold the lookup until the next request.
    always_ff @(posedge clk_i) begin
        if (arr.lookup_en) begin
            lookup_index_q <= lookup_index;
            lookup_tag_q   <= lookup_tag;
        end
    end

    // Arrays are read after the edge, so a write in the lookup cycle
    // is already visible to the compare.
    assign arr.hit     = valid_q[lookup_index_q] && (tag_mem[lookup_index_q] == lookup_tag_q);
    assign arr.rd_line = data_mem[lookup_index_q];

endmodule

// ==== rtl/icache_word_sel.sv ====
`timescale 1ns/1ns

module icache_word_sel (
    input  logic                clk_i,
    input  icache_pkg::addr_t   fetch_addr_i,
    input  logic                lookup_i,
    input  logic                miss_capture_i,
    input  logic                refill_i,
    input  mem_bus_pkg::line_t  rd_line_i,
    input  mem_bus_pkg::line_t  wr_line_i,
    output icache_pkg::instr_t  instr_o
);

    icache_pkg::word_sel_t lookup_word_q;  // Word of the lookup in flight.
    icache_pkg::word_sel_t miss_word_q;    // Word owed by the pending miss.
    icache_pkg::word_sel_t word;
    mem_bus_pkg::line_t    line;

    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            lookup_word_q <= fetch_addr_i[icache_pkg::WORD_LSB +: icache_pkg::WORD_W];
        end
    end

    // Keep the word number until the refill line shows up.
    always_ff @(posedge clk_i) begin
        if (miss_capture_i) begin
            miss_word_q <= lookup_word_q;
        end
    end

    // Refill line during REFILL, otherwise the line read on the hit.
    always_comb begin
        if (refill_i) begin
            word = miss_word_q;
            line = wr_line_i;
        end else begin
            word = lookup_word_q;
            line = rd_line_i;
        end
    end

    // Word 0 lives in the low bits of the line.
    assign instr_o = line[word*icache_pkg::INSTR_W +: icache_pkg::INSTR_W];

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    fetch_valid_i,
    input  icache_pkg::addr_t       fetch_addr_i,
    input  logic                    flush_i,
    output logic                    busy_o,
    output logic                    instr_valid_o,
    output logic                    mem_req_o,
    output mem_bus_pkg::line_addr_t mem_addr_o,
    input  logic                    mem_ready_i,
    input  mem_bus_pkg::line_t      mem_line_i,
    output logic                    miss_capture_o,
    output logic                    refill_o,
    icache_array_if.ctrl            arr
);

    mem_bus_pkg::ctrl_state_t state_q;
    mem_bus_pkg::ctrl_state_t state_d;

    icache_pkg::addr_t  req_addr_q;  // Last accepted address, held while a miss runs.
    mem_bus_pkg::line_t line_q;      // Line returned by memory.
    logic               lookup_q;    // A lookup result is due this cycle.
    logic               flushed_q;   // Redirect seen during the current miss.

    logic accept;
    logic in_lookup;
    logic in_refill;
    logic hit_now;
    logic miss_now;

    assign in_lookup = (state_q == mem_bus_pkg::LOOKUP);
    assign in_refill = (state_q == mem_bus_pkg::REFILL);

    assign hit_now  = in_lookup && lookup_q && arr.hit;
    assign miss_now = in_lookup && lookup_q && !arr.hit;

    // Busy rises in the same cycle the miss shows up.
    assign busy_o = !in_lookup || miss_now;
    assign accept = fetch_valid_i && !busy_o;  // Strobes while busy are dropped.

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_bus_pkg::LOOKUP: begin
                if (miss_now) begin
                    state_d = mem_bus_pkg::MEM_WAIT;
                end
            end
            mem_bus_pkg::MEM_WAIT: begin
                if (mem_ready_i) begin
                    state_d = mem_bus_pkg::REFILL;
                end
            end
            mem_bus_pkg::REFILL: begin
                state_d = mem_bus_pkg::LOOKUP;  // Single write cycle.
            end
            default: begin
                state_d = mem_bus_pkg::LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q   <= mem_bus_pkg::LOOKUP;
            lookup_q  <= 1'b0;
            flushed_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            lookup_q <= accept;
            if (miss_now) begin
                flushed_q <= flush_i;  // Fresh miss starts unflushed unless redirected now.
            end else if (state_q == mem_bus_pkg::MEM_WAIT && flush_i) begin
                flushed_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_addr_q <= fetch_addr_i;
        end
        if (state_q == mem_bus_pkg::MEM_WAIT && mem_ready_i) begin
            line_q <= mem_line_i;
        end
    end

    assign mem_req_o  = miss_now;
    assign mem_addr_o = req_addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];

    assign arr.lookup_en   = accept;
    assign arr.lookup_addr = fetch_addr_i;
    assign arr.wr_en       = in_refill;
    assign arr.wr_addr     = req_addr_q;
    assign arr.wr_line     = line_q;

    assign miss_capture_o = miss_now;
    assign refill_o       = in_refill;

    // The refill still writes after a flush, only the delivery is dropped.
    assign instr_valid_o = hit_now || (in_refill && !flushed_q && !flush_i);

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ns

module icache_top (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Fetch stage.
    input  logic                    fetch_valid_i,
    input  icache_pkg::addr_t       fetch_addr_i,
    input  logic                    flush_i,
    output logic                    busy_o,
    output icache_pkg::instr_t      instr_o,
    output logic                    instr_valid_o,

    // Main memory, read only.
    output logic                    mem_req_o,
    output mem_bus_pkg::line_addr_t mem_addr_o,
    input  logic                    mem_ready_i,
    input  mem_bus_pkg::line_t      mem_line_i
);

    logic miss_capture;
    logic refill;
    logic lookup;

    icache_array_if arr_if ();

    icache_ctrl ctrl_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_addr_i   (fetch_addr_i),
        .flush_i        (flush_i),
        .busy_o         (busy_o),
        .instr_valid_o  (instr_valid_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_ready_i    (mem_ready_i),
        .mem_line_i     (mem_line_i),
        .miss_capture_o (miss_capture),
        .refill_o       (refill),
        .arr            (arr_if.ctrl)
    );

    icache_array array_inst (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .arr   (arr_if.array)
    );

    // The word selector follows the same lookup strobe as the array.
    assign lookup = arr_if.lookup_en;

    icache_word_sel word_sel_inst (
        .clk_i          (clk_i),
        .fetch_addr_i   (fetch_addr_i),
        .lookup_i       (lookup),
        .miss_capture_i (miss_capture),
        .refill_i       (refill),
        .rd_line_i      (arr_if.rd_line),
        .wr_line_i      (arr_if.wr_line),
        .instr_o        (instr_o)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/1ns

module tb_mem_model (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    mem_req_i,
    input  mem_bus_pkg::line_addr_t mem_addr_i,
    output logic                    mem_ready_o,
    output mem_bus_pkg::line_t      mem_line_o
);

    logic [31:0]             rng_q     = 32'ha0de;
    logic                    pending_q = 1'b0;
    logic [2:0]              delay_q   = 3'd0;   // Cycles left before the answer.
    mem_bus_pkg::line_addr_t addr_q    = '0;
    logic                    ready_q   = 1'b0;
    mem_bus_pkg::line_t      line_q    = '0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word k of line L is ((L << 2) + k) ^ 32'h5a5a_0000.
    function automatic mem_bus_pkg::line_t line_pattern(input mem_bus_pkg::line_addr_t a);
        mem_bus_pkg::line_t line;
        int k;
        for (k = 0; k < 4; k++) begin
            line[k*32 +: 32] = (({4'h0, a} << 2) + 32'(k)) ^ 32'h5a5a_0000;
        end
        return line;
    endfunction

    always @(posedge clk_i) begin
        if (!rst_i) begin
            pending_q <= 1'b0;
            ready_q   <= 1'b0;
        end else begin
            ready_q <= 1'b0;  // Answer is a single-cycle strobe.
            if (pending_q) begin
                if (delay_q == 3'd0) begin
                    ready_q   <= 1'b1;
                    line_q    <= line_pattern(addr_q);
                    pending_q <= 1'b0;
                end else begin
                    delay_q <= delay_q - 3'd1;
                end
            end else if (mem_req_i) begin
                rng_q <= xorshift(rng_q);
                if (rng_q[2:0] == 3'd0) begin
                    ready_q <= 1'b1;  // Fastest answer, the cycle after the request.
                    line_q  <= line_pattern(mem_addr_i);
                end else begin
                    pending_q <= 1'b1;
                    addr_q    <= mem_addr_i;
                    delay_q   <= rng_q[2:0] - 3'd1;
                end
            end
        end
    end

    assign mem_ready_o = ready_q;
    assign mem_line_o  = line_q;

endmodule

// ==== sim/tb_icache_top.sv ====
`timescale 1ns/1ns

module tb_icache_top;

    localparam int BUSY_TIMEOUT    = 50;  // Cycles.
    localparam int MEM_TIMEOUT     = 20;
    localparam int RANDOM_ACCESSES = 400;

    logic                    clk_i;
    logic                    rst_i;
    logic                    fetch_valid_i;
    icache_pkg::addr_t       fetch_addr_i;
    logic                    flush_i;
    logic                    busy_o;
    icache_pkg::instr_t      instr_o;
    logic                    instr_valid_o;
    logic                    mem_req_o;
    mem_bus_pkg::line_addr_t mem_addr_o;
    logic                    mem_ready_i;
    mem_bus_pkg::line_t      mem_line_i;

    mem_bus_pkg::ctrl_state_t dut_state;

    // Reference model, one valid bit and tag per line.
    logic [63:0]      model_valid;
    icache_pkg::tag_t model_tag [64];

    logic [31:0] rng;
    int          checks;
    int          errors;
    int          test_num;
    int          test_checks;
    int          test_errors;
    int          req_count = 0;

    icache_top icache_top_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .flush_i       (flush_i),
        .busy_o        (busy_o),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_ready_i   (mem_ready_i),
        .mem_line_i    (mem_line_i)
    );

    tb_mem_model mem_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mem_req_i   (mem_req_o),
        .mem_addr_i  (mem_addr_o),
        .mem_ready_o (mem_ready_i),
        .mem_line_o  (mem_line_i)
    );

    assign dut_state = icache_top_inst.ctrl_inst.state_q;

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Memory requests seen so far.
    always @(negedge clk_i) begin
        if (rst_i && mem_req_o) begin
            req_count <= req_count + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word k of line addr[31:4], per the memory pattern.
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return (({4'h0, addr[31:4]} << 2) + {30'd0, addr[3:2]}) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic predict_hit(input logic [31:0] addr);
        return model_valid[addr[9:4]] && (model_tag[addr[9:4]] == addr[31:10]);
    endfunction

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Fail %0t: %s expected %0b, got %0b (state %s)",
                     $time, name, expected, actual, dut_state.name());
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Fail %0t: %s expected %h, got %h (state %s)",
                     $time, name, expected, actual, dut_state.name());
        end
    endtask

    task automatic check_state(input mem_bus_pkg::ctrl_state_t expected);
        checks++;
        assert (dut_state == expected) else begin
            errors++;
            $display("Fail %0t: state_q expected %s, got %s",
                     $time, expected.name(), dut_state.name());
        end
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    // Called at a falling edge, returns at one.
    task automatic wait_not_busy();
        int waited;
        waited = 0;
        while (busy_o && waited < BUSY_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (busy_o) begin
            abort_on_timeout("busy_o to fall");
        end
    endtask

    // One fetch, checked against the model for hit or miss timing.
    task automatic access(input logic [31:0] addr, input logic do_flush, output logic was_hit);
        logic exp_hit;
        logic dut_hit;
        logic got_ready;
        int   req_before;
        int   waited;
        exp_hit = predict_hit(addr);
        wait_not_busy();
        req_before = req_count;
        @(posedge clk_i);
        fetch_valid_i <= 1'b1;
        fetch_addr_i  <= addr;
        @(posedge clk_i);
        fetch_valid_i <= 1'b0;
        @(negedge clk_i);
        dut_hit = instr_valid_o && !mem_req_o;  // What the cache actually did.
        check_bit("mem_req_o", mem_req_o, !exp_hit);
        check_bit("instr_valid_o", instr_valid_o, exp_hit);
        check_bit("busy_o", busy_o, !exp_hit);
        if (exp_hit) begin
            check_word("instr_o", instr_o, expected_word(addr));
        end else begin
            check_word("mem_addr_o", {4'h0, mem_addr_o}, {4'h0, addr[31:4]});
            got_ready = 1'b0;
            waited = 0;
            while (!got_ready && waited < MEM_TIMEOUT) begin
                @(posedge clk_i);
                flush_i <= do_flush && (waited == 0);  // One pulse in MEM_WAIT.
                @(negedge clk_i);
                got_ready = mem_ready_i;
                waited++;
                check_bit("instr_valid_o", instr_valid_o, 1'b0);
            end
            if (!got_ready) begin
                abort_on_timeout("mem_ready_i");
            end
            @(posedge clk_i);
            flush_i <= 1'b0;
            @(negedge clk_i);
            check_state(mem_bus_pkg::REFILL);
            check_bit("instr_valid_o", instr_valid_o, !do_flush);
            check_bit("busy_o", busy_o, 1'b1);
            if (!do_flush) begin
                check_word("instr_o", instr_o, expected_word(addr));
            end
            @(negedge clk_i);
            check_state(mem_bus_pkg::LOOKUP);
            check_bit("busy_o", busy_o, 1'b0);
            check_word("mem_req_o count", 32'(req_count - req_before), 32'd1);
            model_valid[addr[9:4]] = 1'b1;  // Refill lands even when flushed.
            model_tag[addr[9:4]]   = addr[31:10];
        end
        was_hit = dut_hit;
    endtask

    // Four strobes on consecutive cycles, all expected to hit.
    task automatic hit_burst(input logic [31:0] base);
        int i;
        int req_before;
        wait_not_busy();
        req_before = req_count;
        for (i = 0; i < 5; i++) begin
            @(posedge clk_i);
            fetch_valid_i <= (i < 4);
            fetch_addr_i  <= base + 32'(4 * i);
            @(negedge clk_i);
            if (i > 0) begin
                check_bit("instr_valid_o", instr_valid_o, 1'b1);
                check_word("instr_o", instr_o, expected_word(base + 32'(4 * (i - 1))));
                check_bit("mem_req_o", mem_req_o, 1'b0);
            end
        end
        check_word("mem_req_o count", 32'(req_count - req_before), 32'd0);
    endtask

    task automatic start_test();
        test_num++;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        $display("%0d. %s: %0d checks, %0d errors",
                 test_num, name, checks - test_checks, errors - test_errors);
    endtask

    initial begin
        logic        hit;
        logic        do_flush;
        logic [31:0] addr;
        int          hits;
        int          misses;
        int          n;
        rst_i         = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        flush_i       = 1'b0;
        model_valid   = '0;
        rng           = 32'ha0de;
        checks        = 0;
        errors        = 0;
        test_num      = 0;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b1;

        start_test();
        repeat (5) begin
            @(negedge clk_i);
            check_bit("busy_o", busy_o, 1'b0);
            check_bit("instr_valid_o", instr_valid_o, 1'b0);
            check_bit("mem_req_o", mem_req_o, 1'b0);
        end
        finish_test("idle after reset");

        start_test();
        access(32'h0000_2468, 1'b0, hit);
        finish_test("cold miss");

        start_test();
        hit_burst(32'h0000_2460);
        finish_test("hits on refilled line");

        // Same index 0x23, tags 4 and 5.
        start_test();
        misses = 0;
        for (n = 0; n < 3; n++) begin
            access(32'h0000_1230, 1'b0, hit);
            misses += hit ? 0 : 1;
            access(32'h0000_1634, 1'b0, hit);
            misses += hit ? 0 : 1;
        end
        check_word("eviction misses", 32'(misses), 32'd6);
        finish_test("same index eviction");

        start_test();
        access(32'h0000_3a0c, 1'b1, hit);
        access(32'h0000_3a0c, 1'b0, hit);
        check_bit("hit after flushed refill", hit, 1'b1);
        finish_test("flush during refill");

        start_test();
        hits = 0;
        misses = 0;
        for (n = 0; n < RANDOM_ACCESSES; n++) begin
            rng = xorshift(rng);
            addr = 32'h0001_0000 | (rng & 32'h0000_0ffc);  // 4 KB window.
            rng = xorshift(rng);
            do_flush = !predict_hit(addr) && ((rng % 32'd20) == 32'd0);
            access(addr, do_flush, hit);
            if (hit) begin
                hits++;
            end else begin
                misses++;
            end
            rng = xorshift(rng);
            repeat (rng[1:0]) @(negedge clk_i);  // Idle gap.
        end
        finish_test($sformatf("random accesses (%0d hits, %0d misses)", hits, misses));

        $display("Totals: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/icache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/icache_array_if.sv
rtl/icache_array.sv
rtl/icache_word_sel.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_icache_top \
    -f compile.f \
    -o vsim_icache

./obj_dir/vsim_icache > "$LOG" 2>&1
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi

echo "Simulation finished without errors"
